//--- common/capture_config.svh
`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// cycles the held enable stays up after enable falls or a chirp init
// matches the dds pipeline depth of the tx chain
`define CAP_DDS_LATENCY 2

// fifo depth as log2 of words, 5 -> 32 words
`define CAP_FIFO_DEPTH_LOG2 5

// route fields in the control word, 2 bits each
// code 0 adc, 1 dac, 2 sample count, 3 global count
`define CAP_ROUTE_L_LSB 0   // lower half select
`define CAP_ROUTE_U_LSB 4   // upper half select

// width of one route field
`define CAP_ROUTE_W 2

`endif

//--- common/capture_pkg.sv
package capture_pkg;

  // one i/q sample, i in [31:16], q in [15:0]
  typedef logic [31:0] sample_iq_t;

  // sample counter or global cycle counter value
  typedef logic [31:0] stamp_t;

  // one fifo word, upper half above lower half
  // header words carry {global count, sample count}
  typedef logic [63:0] cap_word_t;

  // source select for one half of a body word
  //   0 adc sample
  //   1 dac sample
  //   2 sample counter
  //   3 global counter
  typedef logic [1:0] route_sel_t;

  // dds latency countdown
  typedef logic [3:0] latency_cnt_t;

  // control word from the host side, only the route fields are used
  typedef logic [31:0] ctrl_word_t;

endpackage

//--- capture/capture_framer.sv
`timescale 1ns/1ps

`include "capture_config.svh"

module capture_framer (
  input  logic                clk_245_76MHz,
  input  logic                cpu_reset,
  input  logic                adc_enable_i,
  input  logic                chirp_init_i,
  input  logic                adc_valid_i,
  output logic                wr_en_o,        // one write per valid sample in the window
  output logic                wr_first_o,     // header marker, registered
  output logic                wr_last_o,      // trailer marker, combinational
  output capture_pkg::stamp_t sample_count_o  // words written since reset
);

  logic                      enable_r;      // one cycle behind adc_enable_i
  logic                      enable_rr;     // enable after the latency hold
  capture_pkg::latency_cnt_t latency_cnt;
  logic                      latency_zero;
  logic                      enable_fall;   // enable just dropped
  logic                      wr_first_r;
  capture_pkg::stamp_t       sample_cnt_r;

  assign latency_zero = (latency_cnt == '0);
  assign enable_fall  = enable_r & ~adc_enable_i;

  // enable sync and hold
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r  <= 1'b0;
      enable_rr <= 1'b0;
    end else begin
      enable_r <= adc_enable_i;
      // frozen while the dds pipeline drains
      if (latency_zero) begin
        enable_rr <= enable_r;
      end
    end
  end

  // latency countdown, chirp init wins over the falling edge
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      latency_cnt <= '0;
    end else if (chirp_init_i || enable_fall) begin
      latency_cnt <= capture_pkg::latency_cnt_t'(`CAP_DDS_LATENCY);
    end else if (!latency_zero) begin
      latency_cnt <= latency_cnt - 1'b1;
    end
  end

  // header marker lands in the first cycle of the held window
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_first_r <= 1'b0;
    end else begin
      wr_first_r <= latency_zero & enable_r & ~enable_rr;
    end
  end

  // every write advances the count, dropped words included
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt_r <= '0;
    end else if (wr_en_o) begin
      sample_cnt_r <= sample_cnt_r + 1'b1;
    end
  end

  assign wr_en_o        = enable_rr & adc_valid_i;
  assign wr_first_o     = wr_first_r;
  assign wr_last_o      = latency_zero & enable_rr & ~enable_r;   // last held cycle
  assign sample_count_o = sample_cnt_r;  // pre-increment value for the header

endmodule

//--- capture/word_mux.sv
`timescale 1ns/1ps

`include "capture_config.svh"

module word_mux (
  input  logic                    clk_245_76MHz,
  input  logic                    cpu_reset,
  input  capture_pkg::ctrl_word_t control_word_i,
  input  capture_pkg::sample_iq_t adc_iq_i,
  input  capture_pkg::sample_iq_t dac_iq_i,
  input  capture_pkg::stamp_t     sample_count_i,
  input  logic                    first_i,
  input  logic                    last_i,
  output capture_pkg::cap_word_t  word_o
);

  capture_pkg::route_sel_t route_u_r;     // upper half source
  capture_pkg::route_sel_t route_l_r;     // lower half source
  capture_pkg::stamp_t     glbl_count_r;  // free running since reset
  capture_pkg::sample_iq_t half_u;
  capture_pkg::sample_iq_t half_l;
  logic                    header_sel;

  // same four way select for both halves
  function automatic capture_pkg::sample_iq_t pick_half(
    input capture_pkg::route_sel_t sel,
    input capture_pkg::sample_iq_t adc,
    input capture_pkg::sample_iq_t dac,
    input capture_pkg::stamp_t     smp,
    input capture_pkg::stamp_t     glb
  );
    case (sel)
      2'd0:    pick_half = adc;
      2'd1:    pick_half = dac;
      2'd2:    pick_half = smp;
      default: pick_half = glb;
    endcase
  endfunction

  // route selects take effect one edge after the control word changes
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_u_r <= '0;
      route_l_r <= '0;
    end else begin
      route_u_r <= control_word_i[`CAP_ROUTE_U_LSB +: `CAP_ROUTE_W];
      route_l_r <= control_word_i[`CAP_ROUTE_L_LSB +: `CAP_ROUTE_W];
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_count_r <= '0;
    end else begin
      glbl_count_r <= glbl_count_r + 1'b1;
    end
  end

  assign half_u     = pick_half(route_u_r, adc_iq_i, dac_iq_i, sample_count_i, glbl_count_r);
  assign half_l     = pick_half(route_l_r, adc_iq_i, dac_iq_i, sample_count_i, glbl_count_r);
  assign header_sel = first_i | last_i;

  // markers replace the body with a time stamp pair
  assign word_o = header_sel ? {glbl_count_r, sample_count_i} : {half_u, half_l};

endmodule

//--- source/sample_fifo.sv
`timescale 1ns/1ps

`include "capture_config.svh"

module sample_fifo (
  input  logic                   clk_245_76MHz,
  input  logic                   cpu_reset,
  input  logic                   wr_en_i,
  input  logic                   first_i,
  input  logic                   last_i,
  input  capture_pkg::cap_word_t word_i,
  input  logic                   out_ready_i,
  output capture_pkg::cap_word_t out_data_o,
  output logic                   out_first_o,
  output logic                   out_last_o,
  output logic                   out_valid_o,
  output logic                   overflow_o
);

  localparam int AW    = `CAP_FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << AW;

  capture_pkg::cap_word_t mem_word [DEPTH];
  logic                   mem_first [DEPTH];
  logic                   mem_last [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   fill;      // one extra bit so full is distinct from empty
  logic          full;
  logic          push;
  logic          pop;
  logic          overflow_r;

  assign full = (fill == DEPTH[AW:0]);
  assign push = wr_en_i & ~full;         // no back-pressure, excess words are lost
  assign pop  = out_valid_o & out_ready_i;

  // storage, flags kept beside each word
  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      mem_word[wr_ptr]  <= word_i;
      mem_first[wr_ptr] <= first_i;
      mem_last[wr_ptr]  <= last_i;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      overflow_r <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;       // both or neither
      endcase
      if (wr_en_i && full) begin
        overflow_r <= 1'b1;          // sticky
      end
    end
  end

  // head entry shown directly, stable until popped
  assign out_data_o  = mem_word[rd_ptr];
  assign out_first_o = mem_first[rd_ptr];
  assign out_last_o  = mem_last[rd_ptr];
  assign out_valid_o = (fill != '0);
  assign overflow_o  = overflow_r;

endmodule

//--- source/capture_top.sv
`timescale 1ns/1ps

module capture_top (
  input  logic                    clk_245_76MHz,
  input  logic                    cpu_reset,
  input  logic                    adc_enable_i,    // capture window, async to framing
  input  logic                    chirp_init_i,    // restarts the latency hold
  input  logic                    adc_valid_i,     // sample strobe, no handshake
  input  logic                    out_ready_i,
  input  capture_pkg::ctrl_word_t control_word_i,
  input  capture_pkg::sample_iq_t adc_iq_i,
  input  capture_pkg::sample_iq_t dac_iq_i,
  output capture_pkg::cap_word_t  out_data_o,
  output logic                    out_first_o,
  output logic                    out_last_o,
  output logic                    out_valid_o,
  output logic                    overflow_o       // sticky until reset
);

  logic                   wr_en;        // write strobe into the fifo
  logic                   wr_first;     // header marker
  logic                   wr_last;      // trailer marker
  capture_pkg::stamp_t    sample_count;
  capture_pkg::cap_word_t wr_word;      // header or routed body word

  capture_framer i_framer (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .adc_enable_i   (adc_enable_i),
    .chirp_init_i   (chirp_init_i),
    .adc_valid_i    (adc_valid_i),
    .wr_en_o        (wr_en),
    .wr_first_o     (wr_first),
    .wr_last_o      (wr_last),
    .sample_count_o (sample_count)
  );

  word_mux i_word_mux (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .control_word_i (control_word_i),
    .adc_iq_i       (adc_iq_i),
    .dac_iq_i       (dac_iq_i),
    .sample_count_i (sample_count),
    .first_i        (wr_first),
    .last_i         (wr_last),
    .word_o         (wr_word)
  );

  sample_fifo i_fifo (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .wr_en_i       (wr_en),
    .first_i       (wr_first),
    .last_i        (wr_last),
    .word_i        (wr_word),
    .out_ready_i   (out_ready_i),
    .out_data_o    (out_data_o),
    .out_first_o   (out_first_o),
    .out_last_o    (out_last_o),
    .out_valid_o   (out_valid_o),
    .overflow_o    (overflow_o)
  );

endmodule

//--- sim/tb_capture_top.sv
`timescale 1ns/1ps

`include "capture_config.svh"

module tb_capture_top;

  localparam int DEPTH = 1 << `CAP_FIFO_DEPTH_LOG2;

  logic                    clk_245_76MHz = 1'b0;
  logic                    cpu_reset;
  logic                    adc_enable_i;
  logic                    chirp_init_i;
  logic                    adc_valid_i;
  logic                    out_ready_i;
  capture_pkg::ctrl_word_t control_word_i;
  capture_pkg::sample_iq_t adc_iq_i;
  capture_pkg::sample_iq_t dac_iq_i;
  capture_pkg::cap_word_t  out_data_o;
  logic                    out_first_o;
  logic                    out_last_o;
  logic                    out_valid_o;
  logic                    overflow_o;

  // reference state, written on rising edges only
  logic                      m_started = 1'b0;
  logic                      m_en_r = 1'b0;
  logic                      m_en_rr = 1'b0;
  logic                      m_first = 1'b0;
  logic                      m_ovf = 1'b0;
  capture_pkg::latency_cnt_t m_lat = '0;
  capture_pkg::route_sel_t   m_route_u = '0;
  capture_pkg::route_sel_t   m_route_l = '0;
  capture_pkg::stamp_t       m_smp = '0;
  capture_pkg::stamp_t       m_glbl = '0;   // value the dut holds at the next edge
  int                        m_fill = 0;
  logic [65:0]               exp_q [$];     // {first, last, word}

  int ready_mode = 0;    // 0 always ready, 1 random gaps, 2 held low
  logic valid_rand = 1'b0;
  int word_errs = 0;
  int flag_errs = 0;
  int other_errs = 0;
  int firsts_seen = 0;
  int lasts_seen = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;

  capture_top i_dut (.*);

  always #10 clk_245_76MHz = ~clk_245_76MHz;

  // adc stand-in, a scramble of the global count
  function automatic capture_pkg::sample_iq_t adc_ref(input capture_pkg::stamp_t g);
    return {g[7:0], ~g[15:8], g[15:0] ^ 16'hc3a5};
  endfunction

  // one half of a body word from the route code table
  function automatic capture_pkg::sample_iq_t source_half(
    input capture_pkg::route_sel_t sel,
    input capture_pkg::sample_iq_t dac,
    input capture_pkg::stamp_t     smp,
    input capture_pkg::stamp_t     glb
  );
    case (sel)
      2'd0:    return adc_ref(glb);
      2'd1:    return dac;
      2'd2:    return smp;
      default: return glb;
    endcase
  endfunction

  function automatic capture_pkg::ctrl_word_t route_ctrl(input capture_pkg::route_sel_t u,
                                                         input capture_pkg::route_sel_t l);
    capture_pkg::ctrl_word_t c;
    c = '0;
    c[`CAP_ROUTE_U_LSB +: 2] = u;
    c[`CAP_ROUTE_L_LSB +: 2] = l;
    return c;
  endfunction

  task automatic check_word(input capture_pkg::cap_word_t got, input capture_pkg::cap_word_t exp,
                            input string what);
    if (got !== exp) begin
      word_errs++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errs++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // framing, routing and fifo fill per the capture rules
  always @(posedge clk_245_76MHz) begin : ref_model
    logic zero;
    logic last;
    logic wr;
    logic pop;
    capture_pkg::cap_word_t word;
    m_started = 1'b1;
    if (cpu_reset) begin
      m_en_r = 1'b0;
      m_en_rr = 1'b0;
      m_first = 1'b0;
      m_ovf = 1'b0;
      m_lat = '0;
      m_route_u = '0;
      m_route_l = '0;
      m_smp = '0;
      m_glbl = '0;
      m_fill = 0;
      exp_q.delete();
    end else begin
      zero = (m_lat == '0);
      last = zero && m_en_rr && !m_en_r;
      wr   = m_en_rr && adc_valid_i;
      pop  = (m_fill != 0) && out_ready_i;
      if (wr) begin
        if (m_first || last) word = {m_glbl, m_smp};   // header, pre-increment count
        else word = {source_half(m_route_u, dac_iq_i, m_smp, m_glbl),
                     source_half(m_route_l, dac_iq_i, m_smp, m_glbl)};
        if (m_fill == DEPTH) begin
          m_ovf = 1'b1;   // full, word lost
        end else begin
          exp_q.push_back({m_first, last, word});
          m_fill++;
        end
      end
      if (pop) m_fill--;
      m_first = zero && m_en_r && !m_en_rr;
      if (zero) m_en_rr = m_en_r;
      if (chirp_init_i || (m_en_r && !adc_enable_i)) begin
        m_lat = capture_pkg::latency_cnt_t'(`CAP_DDS_LATENCY);
      end else if (!zero) begin
        m_lat = m_lat - 4'd1;
      end
      m_en_r = adc_enable_i;
      if (wr) m_smp = m_smp + 32'd1;
      m_glbl = m_glbl + 32'd1;
      m_route_u = control_word_i[`CAP_ROUTE_U_LSB +: 2];
      m_route_l = control_word_i[`CAP_ROUTE_L_LSB +: 2];
    end
  end

  // accepted words against the queue
  always @(posedge clk_245_76MHz) begin : compare_out
    logic [65:0] exp;
    if (!cpu_reset && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("output word %h accepted at %0t with no word expected", out_data_o, $time);
      end else begin
        exp = exp_q.pop_front();
        check_word(out_data_o, exp[63:0], "out_data");
        check_flag(out_first_o, exp[65], "out_first");
        check_flag(out_last_o, exp[64], "out_last");
        if (out_first_o === 1'b1) firsts_seen++;   // markers as the dut flags them
        if (out_last_o === 1'b1) lasts_seen++;
      end
    end
  end

  // status outputs are stable mid cycle
  always @(negedge clk_245_76MHz) begin : check_status
    if (m_started) begin
      check_flag(out_valid_o, m_fill != 0, "out_valid");
      check_flag(overflow_o, m_ovf, "overflow");
    end
  end

  always @(posedge clk_245_76MHz) begin : watchdog
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic drive_cycle();
    adc_iq_i = adc_ref(m_glbl);
    dac_iq_i = $urandom();
    case (ready_mode)
      0:       out_ready_i = 1'b1;
      1:       out_ready_i = ($urandom_range(0, 3) != 0);
      default: out_ready_i = 1'b0;
    endcase
    adc_valid_i = valid_rand ? ($urandom_range(0, 1) == 1) : 1'b1;
  endtask

  task automatic step(input int n);
    repeat (n) begin
      @(negedge clk_245_76MHz);
      drive_cycle();
    end
  endtask

  // framing done and every expected word delivered
  task automatic wait_idle();
    step(1);
    while (exp_q.size() != 0 || m_en_r || m_en_rr || m_lat != '0) step(1);
    step(2);
  endtask

  task automatic capture(input int len);
    adc_enable_i = 1'b1;
    step(len);
    adc_enable_i = 1'b0;
    wait_idle();
  endtask

  initial begin : stimulus
    int lens [4];
    int total_len;
    void'($urandom(32'h4e74_f5e0));
    cpu_reset = 1'b1;
    adc_enable_i = 1'b0;
    chirp_init_i = 1'b0;
    adc_valid_i = 1'b0;
    out_ready_i = 1'b0;
    control_word_i = '0;
    adc_iq_i = '0;
    dac_iq_i = '0;
    total_len = 16 + 20 + 24 + 20 + 40 + 12;
    foreach (lens[i]) begin
      lens[i] = $urandom_range(8, 40);
      total_len += lens[i];
    end
    cycle_limit = 4 * total_len + 3000;   // drains, latency and idle gaps
    step(4);
    cpu_reset = 1'b0;

    step(12);   // idle, enable low
    check_flag(out_valid_o, 1'b0, "idle out_valid");
    check_flag(overflow_o, 1'b0, "idle overflow");

    control_word_i = route_ctrl(2'd2, 2'd2);   // counts in both halves
    capture(16);
    capture(20);
    check_flag(firsts_seen == 2 && lasts_seen == 2, 1'b1, "framing of count captures");

    control_word_i = route_ctrl(2'd3, 2'd0);   // global above adc
    capture(24);
    check_flag(firsts_seen == 3 && lasts_seen == 3, 1'b1, "framing of adc capture");

    control_word_i = route_ctrl(2'd1, 2'd2);   // dac above count, switched mid capture
    adc_enable_i = 1'b1;
    step(10);
    control_word_i = route_ctrl(2'd3, 2'd0);
    step(10);
    adc_enable_i = 1'b0;
    wait_idle();
    check_flag(firsts_seen == 4 && lasts_seen == 4, 1'b1, "framing of route change capture");

    ready_mode = 1;
    valid_rand = 1'b1;
    foreach (lens[i]) capture(lens[i]);
    check_flag(overflow_o, 1'b0, "overflow after random gaps");

    ready_mode = 2;   // fifo fills and drops
    valid_rand = 1'b0;
    adc_enable_i = 1'b1;
    step(40);
    adc_enable_i = 1'b0;
    step(8);
    check_flag(overflow_o, 1'b1, "overflow with ready low");
    ready_mode = 0;
    wait_idle();

    firsts_seen = 0;
    lasts_seen = 0;
    control_word_i = route_ctrl(2'd2, 2'd2);
    adc_enable_i = 1'b1;
    step(12);
    adc_enable_i = 1'b0;
    step(1);
    chirp_init_i = 1'b1;   // reload latency, trailer moves out
    step(1);
    chirp_init_i = 1'b0;
    wait_idle();
    check_flag(firsts_seen == 1 && lasts_seen == 1, 1'b1, "framing of chirp capture");
    check_flag(overflow_o, 1'b1, "overflow stays set");

    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d expected words never came out", exp_q.size());
    end
    $display("errors: word %0d, flag %0d, other %0d", word_errs, flag_errs, other_errs);
    if (word_errs + flag_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
common/capture_pkg.sv
capture/capture_framer.sv
capture/word_mux.sv
source/sample_fifo.sv
source/capture_top.sv
sim/tb_capture_top.sv

//--- Makefile
TOP := tb_capture_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f $(wildcard common/* capture/* source/* sim/*)
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST PASS" sim.log

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
